// ==== src/rv_decode_pkg.sv ====
package rv_decode_pkg;

	// datapath and instruction width
	localparam int XLEN = 32;

	typedef logic [XLEN-1:0] word_t;

	// first fetch address out of reset
	localparam word_t RESET_PC = '0;

	// major opcodes, instr[6:0]
	typedef enum logic [6:0] {
		OP     = 7'b0110011,
		OP_IMM = 7'b0010011,
		LOAD   = 7'b0000011,
		STORE  = 7'b0100011,
		BRANCH = 7'b1100011,
		JAL    = 7'b1101111,
		JALR   = 7'b1100111,
		LUI    = 7'b0110111,
		AUIPC  = 7'b0010111,
		SYSTEM = 7'b1110011
	} opcode_e;

	// alu operation, value is {instr[30], funct3} for r-type
	typedef enum logic [3:0] {
		ALU_ADD  = 4'b0000,
		ALU_SLL  = 4'b0001,
		ALU_SLT  = 4'b0010,
		ALU_SLTU = 4'b0011,
		ALU_XOR  = 4'b0100,
		ALU_SRL  = 4'b0101,
		ALU_OR   = 4'b0110,
		ALU_AND  = 4'b0111,
		// also beq and bne compare
		ALU_SUB  = 4'b1000,
		ALU_BGE  = 4'b1001,
		ALU_BGEU = 4'b1010,
		ALU_SRA  = 4'b1101
	} alu_fn_e;

	// write-back source select
	typedef enum logic [2:0] {
		FN_ALU    = 3'b000,
		FN_PC4    = 3'b001,
		FN_MULDIV = 3'b010,
		FN_IMM    = 3'b011,
		FN_AUIPC  = 3'b100,
		FN_LOAD   = 3'b111
	} fn_sel_e;

	// memory access type, stores have bit 3 set
	typedef enum logic [3:0] {
		MEM_NONE = 4'b0000,
		MEM_LB   = 4'b0001,
		MEM_LH   = 4'b0010,
		MEM_LW   = 4'b0011,
		MEM_LBU  = 4'b0100,
		MEM_LHU  = 4'b0101,
		MEM_SB   = 4'b1110,
		MEM_SH   = 4'b1111,
		MEM_SW   = 4'b1000
	} mem_op_e;

	// m extension op, value equals funct3
	typedef enum logic [2:0] {
		MD_MUL    = 3'b000,
		MD_MULH   = 3'b001,
		MD_MULHSU = 3'b010,
		MD_MULHU  = 3'b011,
		MD_DIV    = 3'b100,
		MD_DIVU   = 3'b101,
		MD_REM    = 3'b110,
		MD_REMU   = 3'b111
	} muldiv_e;

	// operand b source
	typedef enum logic [1:0] {
		B_REG   = 2'b00,
		B_IMM   = 2'b01,
		B_SHAMT = 2'b10
	} b_sel_e;

	// 33 bits, msb first:
	// b_sel[32:31] we[30] fn[29:27] alu_fn[26:23] mem_op[22:19]
	// muldiv[18:16] pc_sel[15:14] jal[13] jalr[12] branch[11] bne[10]
	// lui[9] auipc[8] system[7] ecall[6] mret[5] sret[4] uret[3]
	// wfi[2] illegal[1] csr_we[0]
	typedef struct packed {
		b_sel_e     b_sel;
		logic       we;
		fn_sel_e    fn;
		alu_fn_e    alu_fn;
		mem_op_e    mem_op;
		muldiv_e    muldiv;
		logic [1:0] pc_sel;
		logic       jal;
		logic       jalr;
		logic       branch;
		logic       bne;
		logic       lui;
		logic       auipc;
		logic       system;
		logic       ecall;
		logic       mret;
		logic       sret;
		logic       uret;
		logic       wfi;
		logic       illegal;
		logic       csr_we;
	} ctrl_t;

	// fetched item, pc in the upper word
	typedef struct packed {
		word_t pc;
		word_t instr;
	} fetch_t;

	// decoded record handed to execute
	typedef struct packed {
		word_t      pc;
		logic [4:0] rd;
		logic [4:0] rs1;
		logic [4:0] rs2;
		word_t      imm;
		ctrl_t      ctrl;
	} dec_t;

endpackage

// ==== src/rv_fetch_stage.sv ====
`timescale 1ns/10ps

module rv_fetch_stage (
	input  logic                  i_clk,
	input  logic                  i_rst,
	// wishbone classic master
	output logic                  o_wb_cyc,
	output logic                  o_wb_stb,
	output logic                  o_wb_we,
	output rv_decode_pkg::word_t  o_wb_adr,
	input  rv_decode_pkg::word_t  i_wb_dat,
	input  logic                  i_wb_ack,
	// fetched word slot
	output rv_decode_pkg::fetch_t o_fetch,
	output logic                  o_fetch_valid,
	input  logic                  i_take
);

	typedef enum logic {
		ST_IDLE,
		ST_BUS
	} state_e;

	state_e state;
	rv_decode_pkg::word_t pc;
	logic start;
	logic done;

	// slot empty, or drained this cycle
	assign start = ~o_fetch_valid | i_take;
	// ack only counts inside our own cycle
	assign done = (state == ST_BUS) & i_wb_ack;

	// cyc and stb drop in idle, so one dead cycle after each ack
	assign o_wb_cyc = (state == ST_BUS);
	assign o_wb_stb = (state == ST_BUS);
	// read only port
	assign o_wb_we = 1'b0;
	// pc holds until ack, so adr is stable over the cycle
	assign o_wb_adr = pc;

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			state <= ST_IDLE;
			pc <= rv_decode_pkg::RESET_PC;
			o_fetch_valid <= 1'b0;
		end else begin
			if (i_take) begin
				o_fetch_valid <= 1'b0;
			end
			case (state)
				ST_IDLE: begin
					if (start) begin
						state <= ST_BUS;
					end
				end
				ST_BUS: begin
					if (i_wb_ack) begin
						state <= ST_IDLE;
						pc <= pc + 32'd4;
						o_fetch_valid <= 1'b1;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// word and its address
	always_ff @(posedge i_clk) begin
		if (done) begin
			o_fetch.pc <= pc;
			o_fetch.instr <= i_wb_dat;
		end
	end

endmodule

// ==== src/instr_decoder.sv ====
`timescale 1ns/10ps

module instr_decoder (
	input  rv_decode_pkg::word_t i_instr,
	// level from commit side
	input  logic                 i_exception_pending,
	output rv_decode_pkg::ctrl_t o_ctrl
);

	rv_decode_pkg::opcode_e opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [11:0] funct12;
	logic bit30;
	// class writes rd, before exception gating
	logic we_class;
	rv_decode_pkg::ctrl_t ctrl;

	assign opcode = rv_decode_pkg::opcode_e'(i_instr[6:0]);
	assign funct3 = i_instr[14:12];
	assign funct7 = i_instr[31:25];
	assign funct12 = i_instr[31:20];
	assign bit30 = i_instr[30];

	always_comb begin
		ctrl = '0;
		we_class = 1'b0;
		case (opcode)
			rv_decode_pkg::OP: begin
				we_class = 1'b1;
				// {bit30, funct3}, unused pairs fall back to add
				if (!bit30 || funct3 == 3'b000 || funct3 == 3'b101) begin
					ctrl.alu_fn = rv_decode_pkg::alu_fn_e'({bit30, funct3});
				end
				// funct7 == 0000001 selects m extension
				if (funct7 == 7'b0000001) begin
					ctrl.fn = rv_decode_pkg::FN_MULDIV;
					ctrl.muldiv = rv_decode_pkg::muldiv_e'(funct3);
				end
			end
			rv_decode_pkg::OP_IMM: begin
				we_class = 1'b1;
				// bit30 only means sra on funct3 101
				ctrl.alu_fn = rv_decode_pkg::alu_fn_e'({bit30 & (funct3 == 3'b101), funct3});
				if (funct3 == 3'b001 || funct3 == 3'b101) begin
					ctrl.b_sel = rv_decode_pkg::B_SHAMT;
				end else begin
					ctrl.b_sel = rv_decode_pkg::B_IMM;
				end
			end
			rv_decode_pkg::LOAD: begin
				we_class = 1'b1;
				ctrl.b_sel = rv_decode_pkg::B_IMM;
				ctrl.fn = rv_decode_pkg::FN_LOAD;
				case (funct3)
					3'b000: ctrl.mem_op = rv_decode_pkg::MEM_LB;
					3'b001: ctrl.mem_op = rv_decode_pkg::MEM_LH;
					3'b010: ctrl.mem_op = rv_decode_pkg::MEM_LW;
					3'b100: ctrl.mem_op = rv_decode_pkg::MEM_LBU;
					3'b101: ctrl.mem_op = rv_decode_pkg::MEM_LHU;
					default: ctrl.mem_op = rv_decode_pkg::MEM_NONE;
				endcase
			end
			rv_decode_pkg::STORE: begin
				// address is rs1 + imm, rs2 goes to memory
				ctrl.b_sel = rv_decode_pkg::B_IMM;
				case (funct3)
					3'b000: ctrl.mem_op = rv_decode_pkg::MEM_SB;
					3'b001: ctrl.mem_op = rv_decode_pkg::MEM_SH;
					3'b010: ctrl.mem_op = rv_decode_pkg::MEM_SW;
					default: ctrl.mem_op = rv_decode_pkg::MEM_NONE;
				endcase
			end
			rv_decode_pkg::BRANCH: begin
				ctrl.branch = 1'b1;
				ctrl.pc_sel = 2'b10;
				ctrl.bne = (funct3 == 3'b001);
				// compare op, beq and bne share sub
				case (funct3)
					3'b000, 3'b001: ctrl.alu_fn = rv_decode_pkg::ALU_SUB;
					3'b100: ctrl.alu_fn = rv_decode_pkg::ALU_SLT;
					3'b101: ctrl.alu_fn = rv_decode_pkg::ALU_BGE;
					3'b110: ctrl.alu_fn = rv_decode_pkg::ALU_SLTU;
					3'b111: ctrl.alu_fn = rv_decode_pkg::ALU_BGEU;
					default: ctrl.alu_fn = rv_decode_pkg::ALU_ADD;
				endcase
			end
			rv_decode_pkg::JAL: begin
				we_class = 1'b1;
				ctrl.jal = 1'b1;
				ctrl.pc_sel = 2'b10;
				ctrl.fn = rv_decode_pkg::FN_PC4;
			end
			rv_decode_pkg::JALR: begin
				we_class = 1'b1;
				ctrl.jalr = 1'b1;
				ctrl.pc_sel = 2'b10;
				ctrl.fn = rv_decode_pkg::FN_PC4;
				// target from rs1 + imm
				ctrl.b_sel = rv_decode_pkg::B_IMM;
			end
			rv_decode_pkg::LUI: begin
				we_class = 1'b1;
				ctrl.lui = 1'b1;
				ctrl.fn = rv_decode_pkg::FN_IMM;
			end
			rv_decode_pkg::AUIPC: begin
				we_class = 1'b1;
				ctrl.auipc = 1'b1;
				ctrl.fn = rv_decode_pkg::FN_AUIPC;
			end
			rv_decode_pkg::SYSTEM: begin
				ctrl.system = 1'b1;
				if (funct3 == 3'b000) begin
					ctrl.ecall = (funct12 == 12'h000);
					ctrl.wfi = (funct12 == 12'h105);
					// xret all have rs2 field 00010, funct7 picks privilege
					if (funct12[4:0] == 5'b00010) begin
						ctrl.uret = (funct7 == 7'b0000000);
						ctrl.sret = (funct7 == 7'b0001000);
						ctrl.mret = (funct7 == 7'b0011000);
					end
				end
			end
			default: ctrl.illegal = 1'b1;
		endcase
		// pending exception blocks register write-back
		ctrl.we = we_class & ~i_exception_pending;
		ctrl.csr_we = ctrl.system | i_exception_pending;
	end

	assign o_ctrl = ctrl;

endmodule

// ==== src/rv_operand_stage.sv ====
`timescale 1ns/10ps

module rv_operand_stage (
	input  logic                  i_clk,
	input  logic                  i_rst,
	input  rv_decode_pkg::fetch_t i_fetch,
	input  logic                  i_fetch_valid,
	input  rv_decode_pkg::ctrl_t  i_ctrl,
	// frees the fetch slot
	output logic                  o_take,
	// downstream valid/ready
	output rv_decode_pkg::dec_t   o_dec,
	output logic                  o_dec_valid,
	input  logic                  i_dec_ready
);

	rv_decode_pkg::word_t instr;
	rv_decode_pkg::opcode_e opcode;
	rv_decode_pkg::word_t imm;

	assign instr = i_fetch.instr;
	assign opcode = rv_decode_pkg::opcode_e'(instr[6:0]);

	// immediate by format, always sign extended from bit 31
	always_comb begin
		case (opcode)
			rv_decode_pkg::OP_IMM, rv_decode_pkg::LOAD,
			rv_decode_pkg::JALR, rv_decode_pkg::SYSTEM: begin
				// i form
				imm = {{20{instr[31]}}, instr[31:20]};
			end
			rv_decode_pkg::STORE: begin
				// s form
				imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
			end
			rv_decode_pkg::BRANCH: begin
				// b form, bit 0 always zero
				imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
			end
			rv_decode_pkg::LUI, rv_decode_pkg::AUIPC: begin
				// u form
				imm = {instr[31:12], 12'b0};
			end
			rv_decode_pkg::JAL: begin
				// j form
				imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
			end
			// r-type and illegal
			default: imm = '0;
		endcase
	end

	// load when empty or drained on this edge
	assign o_take = i_fetch_valid & (~o_dec_valid | i_dec_ready);

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			o_dec_valid <= 1'b0;
		end else if (o_take) begin
			o_dec_valid <= 1'b1;
		end else if (i_dec_ready) begin
			o_dec_valid <= 1'b0;
		end
	end

	// record only changes on take, so it holds under stall
	always_ff @(posedge i_clk) begin
		if (o_take) begin
			o_dec.pc <= i_fetch.pc;
			o_dec.rd <= instr[11:7];
			o_dec.rs1 <= instr[19:15];
			o_dec.rs2 <= instr[24:20];
			o_dec.imm <= imm;
			o_dec.ctrl <= i_ctrl;
		end
	end

endmodule

// ==== src/rv_decode_top.sv ====
`timescale 1ns/10ps

module rv_decode_top (
	input  logic                 i_clk,
	input  logic                 i_rst,
	// instruction bus
	output logic                 o_wb_cyc,
	output logic                 o_wb_stb,
	output logic                 o_wb_we,
	output rv_decode_pkg::word_t o_wb_adr,
	input  rv_decode_pkg::word_t i_wb_dat,
	input  logic                 i_wb_ack,
	input  logic                 i_exception_pending,
	// decoded stream out
	output rv_decode_pkg::dec_t  o_dec,
	output logic                 o_dec_valid,
	input  logic                 i_dec_ready
);

	rv_decode_pkg::fetch_t fetch;
	logic fetch_valid;
	logic take;
	rv_decode_pkg::ctrl_t ctrl;

	// wishbone fetch into one-word slot
	rv_fetch_stage u_fetch (
		.i_clk         (i_clk),
		.i_rst         (i_rst),
		.o_wb_cyc      (o_wb_cyc),
		.o_wb_stb      (o_wb_stb),
		.o_wb_we       (o_wb_we),
		.o_wb_adr      (o_wb_adr),
		.i_wb_dat      (i_wb_dat),
		.i_wb_ack      (i_wb_ack),
		.o_fetch       (fetch),
		.o_fetch_valid (fetch_valid),
		.i_take        (take)
	);

	// combinational on the slot contents
	instr_decoder u_decoder (
		.i_instr             (fetch.instr),
		.i_exception_pending (i_exception_pending),
		.o_ctrl              (ctrl)
	);

	rv_operand_stage u_operand (
		.i_clk         (i_clk),
		.i_rst         (i_rst),
		.i_fetch       (fetch),
		.i_fetch_valid (fetch_valid),
		.i_ctrl        (ctrl),
		.o_take        (take),
		.o_dec         (o_dec),
		.o_dec_valid   (o_dec_valid),
		.i_dec_ready   (i_dec_ready)
	);

endmodule

// ==== tests/tb_rv_decode_top.sv ====
`timescale 1ns/10ps

module tb_rv_decode_top;

	localparam int NPAT = 21;
	localparam int TIMEOUT = 2000;
	localparam time DRIVE = 2;

	logic clk;
	logic rst;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	rv_decode_pkg::word_t wb_adr;
	rv_decode_pkg::word_t wb_dat;
	logic wb_ack;
	logic exc_pending;
	rv_decode_pkg::dec_t dec;
	logic dec_valid;
	logic dec_ready;

	// three entries per line: instr, imm, ctrl
	logic [35:0] pat [0:3*NPAT-1];
	integer seed = 32'hf7e8;
	int mismatch_count = 0;
	int fault_count = 0;
	int got = 0;
	logic run_active = 1'b0;
	logic pend_run = 1'b0;
	logic held_valid = 1'b0;
	rv_decode_pkg::dec_t held_dec;

	rv_decode_top DUT (
		.i_clk               (clk),
		.i_rst               (rst),
		.o_wb_cyc            (wb_cyc),
		.o_wb_stb            (wb_stb),
		.o_wb_we             (wb_we),
		.o_wb_adr            (wb_adr),
		.i_wb_dat            (wb_dat),
		.i_wb_ack            (wb_ack),
		.i_exception_pending (exc_pending),
		.o_dec               (dec),
		.o_dec_valid         (dec_valid),
		.i_dec_ready         (dec_ready)
	);

	task automatic check_word(input string name, input rv_decode_pkg::word_t exp,
			input rv_decode_pkg::word_t act);
		if (act !== exp) begin
			mismatch_count++;
			$display("MISMATCH %s expected %08h actual %08h", name, exp, act);
		end
	endtask

	task automatic check_ctrl(input string name, input rv_decode_pkg::ctrl_t exp,
			input rv_decode_pkg::ctrl_t act);
		if (act !== exp) begin
			mismatch_count++;
			$display("MISMATCH %s expected %09h actual %09h", name, exp, act);
		end
	endtask

	task automatic check_reg(input string name, input logic [4:0] exp,
			input logic [4:0] act);
		if (act !== exp) begin
			mismatch_count++;
			$display("MISMATCH %s expected %0d actual %0d", name, exp, act);
		end
	endtask

	task automatic check_dec(input string name, input rv_decode_pkg::dec_t exp,
			input rv_decode_pkg::dec_t act);
		if (act !== exp) begin
			mismatch_count++;
			$display("MISMATCH %s expected %h actual %h", name, exp, act);
		end
	endtask

	// words past the pattern table just echo their address
	function automatic rv_decode_pkg::word_t mem_word(input rv_decode_pkg::word_t adr);
		int idx;
		idx = int'(adr >> 2);
		if (adr < rv_decode_pkg::word_t'(4 * NPAT)) begin
			return pat[3*idx][31:0];
		end
		return adr;
	endfunction

	task automatic report_and_finish();
		$display("mismatches: %0d, other errors: %0d", mismatch_count, fault_count);
		if (mismatch_count == 0 && fault_count == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	endtask

	initial begin : clock_gen
		clk = 1'b0;
		forever begin
			#20;
			clk = ~clk;
		end
	end

	// wishbone slave with 0 to 3 wait cycles, plus the consumer ready
	initial begin : bus_and_consumer
		int delay;
		int stall_left;
		logic busy;
		wb_ack = 1'b0;
		wb_dat = '0;
		dec_ready = 1'b0;
		delay = 0;
		stall_left = 0;
		busy = 1'b0;
		forever begin
			@(posedge clk);
			#DRIVE;
			if (wb_ack) begin
				// master sampled it on this edge
				wb_ack = 1'b0;
				busy = 1'b0;
			end else if (wb_cyc && wb_stb) begin
				if (!busy) begin
					busy = 1'b1;
					delay = int'($unsigned($random(seed)) % 4);
				end
				if (delay == 0) begin
					wb_ack = 1'b1;
					wb_dat = mem_word(wb_adr);
				end else begin
					delay--;
				end
			end else begin
				busy = 1'b0;
			end
			if (!run_active) begin
				dec_ready = 1'b0;
				stall_left = 0;
			end else if (stall_left > 0) begin
				dec_ready = 1'b0;
				stall_left--;
			end else begin
				dec_ready = 1'b1;
				// back-pressure phase about one cycle in four
				if ($unsigned($random(seed)) % 4 == 0) begin
					stall_left = 1 + int'($unsigned($random(seed)) % 6);
				end
			end
		end
	end

	// sampled mid-cycle, a transfer happens at the next rising edge
	always @(negedge clk) begin : monitor
		rv_decode_pkg::ctrl_t exp_ctrl;
		rv_decode_pkg::word_t instr;
		string tag;
		if (!run_active) begin
			got = 0;
			held_valid = 1'b0;
		end else if (dec_valid) begin
			if (held_valid) begin
				check_dec("stall hold", held_dec, dec);
			end
			if (dec_ready && got < NPAT) begin
				tag = $sformatf("run%0d item%0d", pend_run, got);
				instr = pat[3*got][31:0];
				exp_ctrl = rv_decode_pkg::ctrl_t'(pat[3*got+2][32:0]);
				// pending exception kills write-back, forces csr path
				if (pend_run) begin
					exp_ctrl.we = 1'b0;
					exp_ctrl.csr_we = 1'b1;
				end
				check_word({tag, " pc"}, rv_decode_pkg::word_t'(4 * got), dec.pc);
				check_word({tag, " imm"}, pat[3*got+1][31:0], dec.imm);
				check_ctrl({tag, " ctrl"}, exp_ctrl, dec.ctrl);
				// register index fields sit at fixed isa positions
				check_reg({tag, " rd"}, instr[11:7], dec.rd);
				check_reg({tag, " rs1"}, instr[19:15], dec.rs1);
				check_reg({tag, " rs2"}, instr[24:20], dec.rs2);
				got++;
				held_valid = 1'b0;
			end else begin
				held_valid = 1'b1;
				held_dec = dec;
			end
		end else begin
			held_valid = 1'b0;
		end
	end

	initial begin : main
		int cycles;
		rst = 1'b1;
		exc_pending = 1'b0;
		$readmemh("tests/decode_patterns.hex", pat);
		// second pass runs with an exception pending throughout
		for (int r = 0; r < 2; r++) begin
			@(posedge clk);
			#DRIVE;
			rst = 1'b1;
			pend_run = (r == 1);
			exc_pending = (r == 1);
			repeat (10) @(posedge clk);
			#DRIVE;
			if (wb_cyc || wb_stb || wb_we || dec_valid) begin
				fault_count++;
				$display("bus or output valid still active during reset in run %0d", r);
			end
			if (wb_adr !== rv_decode_pkg::RESET_PC) begin
				fault_count++;
				$display("fetch address is not the reset PC in run %0d", r);
			end
			rst = 1'b0;
			run_active = 1'b1;
			for (cycles = 0; cycles < TIMEOUT && got < NPAT; cycles++) begin
				@(posedge clk);
			end
			run_active = 1'b0;
			if (got < NPAT) begin
				fault_count++;
				$display("timeout: only %0d of %0d decoded items arrived in run %0d",
					got, NPAT, r);
				break;
			end
		end
		report_and_finish();
	end

endmodule

// ==== tests/decode_patterns.hex ====
// instruction word, expected immediate, expected ctrl_t (33 bits, packing in rv_decode_pkg)
// line k is the instruction at address 4k
00a00093 0000000a 0c0000000 // addi x1, x0, 10
00309113 00000003 140800000 // slli x2, x1, 3
40415193 00000404 146800000 // srai x3, x2, 4
fff1c213 ffffffff 0c2000000 // xori x4, x3, -1
403202b3 00000000 044000000 // sub x5, x4, x3
026283b3 00000000 050000000 // mul x7, x5, x6
0263d433 00000000 052850000 // divu x8, x7, x6
ffc0a503 fffffffc 0f8180000 // lw x10, -4(x1)
00512423 00000008 080400000 // sw x5, 8(x2)
fe618fa3 ffffffff 080700000 // sb x6, -1(x3)
fe209ce3 fffffff8 004008c00 // bne x1, x2, -8
001000ef 00000800 04800a000 // jal x1, 2048
00408067 00000004 0c8009000 // jalr x0, 4(x1)
12345637 12345000 058000200 // lui x12, 0x12345
fffff697 fffff000 060000100 // auipc x13, 0xfffff
00000073 00000000 0000000c1 // ecall
30200073 00000302 0000000a1 // mret
10200073 00000102 000000091 // sret
00200073 00000002 000000089 // uret
10500073 00000105 000000085 // wfi
0000000f 00000000 000000002 // fence, not decoded so illegal

// ==== rv_decode_top.f ====
src/rv_decode_pkg.sv
src/rv_fetch_stage.sv
src/instr_decoder.sv
src/rv_operand_stage.sv
src/rv_decode_top.sv
tests/tb_rv_decode_top.sv

// ==== Makefile ====
TOP := tb_rv_decode_top

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f rv_decode_top.f --top-module $(TOP)

obj_dir/V$(TOP): rv_decode_top.f src/*.sv tests/*.sv
	verilator --binary --timing -f rv_decode_top.f --top-module $(TOP)

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q -F '** PASS **' sim.log

clean:
	rm -rf obj_dir sim.log
